// File: build.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/instr_decode.sv
src/reg_file.sv
src/id_exe.sv
src/alu.sv
src/exec_front.sv
dv/exec_front_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module exec_front_tb \
	-f build.f -o sim_exec_front || exit 1
out="$(./obj_dir/sim_exec_front)"
echo "$out"
echo "$out" | grep -qx "Done: no errors" && echo "PASS" && exit 0 || echo "FAIL"
exit 1

// File: dv/exec_front_tb.sv
`timescale 1ns/10ps

module exec_front_tb
	import isa_pkg::*;
	import pipe_pkg::*;
();

	typedef struct packed {
		word_t    instr;
		word_t    pc;
		logic     in_valid;
		logic     hold;
		logic     flush;
		wb_t      wb;
		exe_out_t exp; // What this instruction alone should produce
	} row_t;

	// Branches, jumps, NOP, an unused major opcode and an unused ADDU/SUBU sub-field
	localparam word_t NO_EXEC [11] = '{
		{5'b00010, 11'h155}, {5'b00100, 3'd1, 8'h12}, {5'b00101, 3'd2, 8'hf0},
		{5'b01100, 3'b000, 8'h04}, {5'b01100, 3'b001, 8'h84}, {5'b11101, 3'd3, 8'h00},
		{5'b11101, 3'd0, 8'h20}, {5'b11101, 3'd4, 8'hc0}, 16'h0800, 16'hf800,
		{5'b11100, 3'd1, 3'd2, 3'd3, 2'b10}
	};

	logic        clk = 1'b0;
	logic        rst_n;
	word_t       instr;
	word_t       pc;
	logic        in_valid;
	logic        hold;
	logic        flush;
	wb_t         wb;
	exe_out_t    exe_out;
	logic [31:0] mem_count;

	row_t        rows [$];
	word_t       mregs [NUM_REGS]; // Register model
	logic [31:0] rnd_state = 32'hb8c3;
	bit          table_done = 1'b0;
	int          errors = 0;
	int          checks = 0;
	int          cur_row = -1;

	always #4 clk = ~clk;

	exec_front #(
		.COUNT_W (32)
	) dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.instr     (instr),
		.pc        (pc),
		.in_valid  (in_valid),
		.hold      (hold),
		.flush     (flush),
		.wb        (wb),
		.exe_out   (exe_out),
		.mem_count (mem_count)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic word_t next_word();
		rnd_state = xorshift32(rnd_state);
		return rnd_state[15:0];
	endfunction

	////////////////////
	// Reference model

	function automatic exe_out_t reg_result(input reg_idx_t dst, input word_t val);
		exe_out_t e;
		e = '0;
		e.valid = 1'b1;
		e.reg_write = 1'b1;
		e.reg_addr = dst;
		e.result = val;
		return e;
	endfunction

	function automatic exe_out_t store_result(input word_t addr, input word_t data);
		exe_out_t e;
		e = '0;
		e.valid = 1'b1;
		e.mem_write = 1'b1;
		e.result = addr;
		e.store_value = data;
		return e;
	endfunction

	function automatic exe_out_t predict(input word_t i, input word_t ipc);
		exe_out_t e;
		reg_idx_t x;
		reg_idx_t y;
		reg_idx_t z;
		word_t    s8;
		word_t    s5;
		word_t    s4;
		word_t    sh;
		x = {1'b0, i[10:8]};
		y = {1'b0, i[7:5]};
		z = {1'b0, i[4:2]};
		s8 = {{8{i[7]}}, i[7:0]};
		s5 = {{11{i[4]}}, i[4:0]};
		s4 = {{12{i[3]}}, i[3:0]};
		sh = (i[4:2] == 3'd0) ? 16'd8 : {13'd0, i[4:2]}; // Zero field is 8
		e = '0;
		case (major_op_e'(i[15:11]))
			OP_ADDIU:  e = reg_result(x, mregs[x] + s8);
			OP_ADDIU3: e = reg_result(y, mregs[x] + s4);
			OP_LI:     e = reg_result(x, {8'h00, i[7:0]});
			OP_SP_GRP: begin
				if (i[10:8] == 3'b011)
					e = reg_result(SP_IDX, mregs[SP_IDX] + s8);
				else if (i[10:8] == 3'b100 && i[4:0] == 5'd0)
					e = reg_result(SP_IDX, mregs[y]); // MTSP
			end
			OP_MOVE: begin
				if (i[4:0] == 5'd0)
					e = reg_result(x, mregs[y]);
			end
			OP_RRR: begin
				if (i[1:0] == 2'b01)
					e = reg_result(z, mregs[x] + mregs[y]); // ADDU
				else if (i[1:0] == 2'b11)
					e = reg_result(z, mregs[x] - mregs[y]); // SUBU
			end
			OP_RR: begin
				case (i[4:0])
					5'b01100: e = reg_result(x, mregs[x] & mregs[y]);
					5'b01101: e = reg_result(x, mregs[x] | mregs[y]);
					5'b01010: e = reg_result(T_IDX, (mregs[x] != mregs[y]) ? 16'd1 : 16'd0);
					5'b00111: e = reg_result(x, word_t'($signed(mregs[y]) >>> mregs[x][3:0]));
					default: begin
						if (i[7:0] == 8'h40)
							e = reg_result(x, ipc + 16'd1); // MFPC
					end
				endcase
			end
			OP_IH: begin
				if (i[7:0] == 8'h00)
					e = reg_result(x, mregs[IH_IDX]);
				else if (i[4:0] == 5'b00001)
					e = reg_result(IH_IDX, mregs[x]);
			end
			OP_SHIFT: begin
				if (i[1:0] == 2'b00)
					e = reg_result(x, mregs[y] << sh);
				else if (i[1:0] == 2'b10)
					e = reg_result(x, mregs[y] >> sh);
				else if (i[1:0] == 2'b11)
					e = reg_result(x, word_t'($signed(mregs[y]) >>> sh));
			end
			OP_LW: begin
				e = reg_result(y, mregs[x] + s5);
				e.mem_read = 1'b1;
			end
			OP_LW_SP: begin
				e = reg_result(x, mregs[SP_IDX] + s8);
				e.mem_read = 1'b1;
			end
			OP_SW:    e = store_result(mregs[x] + s5, mregs[y]);
			OP_SW_SP: e = store_result(mregs[SP_IDX] + s8, mregs[x]);
			default:  e = '0;
		endcase
		return e;
	endfunction

	////////////////////
	// Table building

	task automatic add_row(input word_t i, input logic v, input logic h, input logic f,
			input wb_t w);
		row_t r;
		r.instr = i;
		r.pc = next_word();
		r.in_valid = v;
		r.hold = h;
		r.flush = f;
		r.wb = w;
		if (v)
			r.exp = predict(i, r.pc); // Reads see the old value
		else
			r.exp = '0;
		if (w.en && int'(w.addr) < NUM_REGS)
			mregs[w.addr] = w.data;
		rows.push_back(r);
	endtask

	task automatic queue_instr(input word_t i);
		add_row(i, 1'b1, 1'b0, 1'b0, '0);
	endtask

	task automatic preload_reg(input reg_idx_t a, input word_t d);
		wb_t w;
		w.en = 1'b1;
		w.addr = a;
		w.data = d;
		add_row(16'h0800, 1'b0, 1'b0, 1'b0, w);
	endtask

	////////////////////
	// Checking

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("ERROR %s expected %h actual %h (row %0d)", name, exp, act, cur_row);
		end
	endtask

	task automatic check_out(input exe_out_t exp);
		check_val("exe_out.valid", exp.valid, exe_out.valid);
		check_val("exe_out.result", exp.result, exe_out.result);
		check_val("exe_out.reg_write", exp.reg_write, exe_out.reg_write);
		check_val("exe_out.reg_addr", exp.reg_addr, exe_out.reg_addr);
		check_val("exe_out.mem_read", exp.mem_read, exe_out.mem_read);
		check_val("exe_out.mem_write", exp.mem_write, exe_out.mem_write);
		check_val("exe_out.store_value", exp.store_value, exe_out.store_value);
	endtask

	initial begin
		wait (table_done);
		#((rows.size() + 4) * 32);
		$display("Timeout: the stimulus table did not finish in time");
		$display("Done: errors found");
		$finish;
	end

	initial begin
		exe_out_t    exp_stage;
		exe_out_t    exp_out;
		logic [31:0] exp_count;
		word_t       v;
		wb_t         w;
		rst_n = 1'b0;
		instr = '0;
		pc = '0;
		in_valid = 1'b0;
		hold = 1'b0;
		flush = 1'b0;
		wb = '0;
		for (int k = 0; k < NUM_REGS; k++)
			mregs[k] = '0;

		// Registers read back as zero after reset
		for (int k = 0; k < 8; k++)
			queue_instr({5'b01111, 3'(k + 1), 3'(k), 5'b00000});
		queue_instr({5'b11110, 3'd2, 8'h00});
		queue_instr({5'b01100, 3'b011, 8'h00});
		for (int k = 0; k < 14; k++)
			preload_reg(4'(k), next_word()); // 12 and 13 are dropped
		for (int k = 0; k < 4; k++) begin
			queue_instr({5'b11100, 3'(k), 3'(k + 3), 3'(7 - k), 2'b01});
			queue_instr({5'b11100, 3'(k), 3'(k + 3), 3'(7 - k), 2'b11});
			queue_instr({5'b11101, 3'(k), 3'(k + 3), 5'b01100});
			queue_instr({5'b11101, 3'(k), 3'(k + 3), 5'b01101});
			queue_instr({5'b11101, 3'(k), 3'(k + 3), 5'b01010});
			queue_instr({5'b11101, 3'(k), 3'(k + 3), 5'b00111});
		end
		queue_instr({5'b11101, 3'd5, 3'd5, 5'b01010}); // Equal operands
		w.en = 1'b1;
		w.addr = 4'd1;
		w.data = next_word();
		add_row({5'b11100, 3'd1, 3'd1, 3'd2, 2'b01}, 1'b1, 1'b0, 1'b0, w);
		for (int s = 0; s < 2; s++) begin
			v = next_word();
			v[7] = s[0];
			v[4] = s[0];
			v[3] = s[0];
			queue_instr({5'b01001, 3'd1, v[7:0]});
			queue_instr({5'b01000, 3'd2, 3'd6, 1'b0, v[3:0]});
			queue_instr({5'b01100, 3'b011, v[7:0]});
			queue_instr({5'b01101, 3'd3, v[7:0]});
			queue_instr({5'b01111, 3'd4, 3'(s + 5), 5'b00000});
			queue_instr({5'b11101, 3'd5, 8'h40});
			queue_instr({5'b11110, 3'd6, 8'h00});
			queue_instr({5'b11110, 3'(s), 3'b000, 5'b00001});
			queue_instr({5'b01100, 3'b100, 3'(s + 2), 5'b00000});
			queue_instr({5'b10011, 3'd1, 3'd2, v[4:0]}); // Memory forms
			queue_instr({5'b10010, 3'd3, v[7:0]});
			queue_instr({5'b11011, 3'd4, 3'd5, v[4:0]});
			queue_instr({5'b11010, 3'd6, v[7:0]});
		end
		for (int k = 0; k < 8; k++) begin
			queue_instr({5'b00110, 3'd1, 3'(7 - k), 3'(k), 2'b00});
			queue_instr({5'b00110, 3'd2, 3'(7 - k), 3'(k), 2'b10});
			queue_instr({5'b00110, 3'd3, 3'(7 - k), 3'(k), 2'b11});
		end
		queue_instr({5'b10011, 3'd1, 3'd2, 5'h03});
		queue_instr({5'b11100, 3'd1, 3'd2, 3'd3, 2'b01});
		repeat (3)
			add_row({5'b11011, 3'd4, 3'd5, 5'h01}, 1'b1, 1'b1, 1'b0, '0);
		add_row({5'b11011, 3'd4, 3'd5, 5'h01}, 1'b1, 1'b1, 1'b1, '0); // Hold beats flush
		add_row({5'b11011, 3'd4, 3'd5, 5'h01}, 1'b1, 1'b0, 1'b1, '0);
		add_row({5'b11100, 3'd1, 3'd2, 3'd3, 2'b01}, 1'b0, 1'b0, 1'b0, '0);
		foreach (NO_EXEC[k])
			queue_instr(NO_EXEC[k]);
		repeat (2)
			add_row(16'h0800, 1'b0, 1'b0, 1'b0, '0); // Drain
		table_done = 1'b1;

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_out('0);
		check_val("mem_count", 32'd0, mem_count);

		exp_stage = '0;
		exp_out = '0;
		exp_count = '0;
		foreach (rows[k]) begin
			cur_row = k;
			instr = rows[k].instr;
			pc = rows[k].pc;
			in_valid = rows[k].in_valid;
			hold = rows[k].hold;
			flush = rows[k].flush;
			wb = rows[k].wb;
			@(posedge clk);
			if (!rows[k].hold) begin // Two-stage pipe, frozen by hold
				exp_out = exp_stage;
				if (rows[k].flush)
					exp_stage = '0;
				else
					exp_stage = rows[k].exp;
				if (exp_stage.mem_read || exp_stage.mem_write)
					exp_count = exp_count + 32'd1;
			end
			@(negedge clk);
			check_out(exp_out);
			check_val("mem_count", exp_count, mem_count);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: src/exec_front.sv
`timescale 1ns/10ps

module exec_front
	import isa_pkg::*;
	import pipe_pkg::*;
#(
	parameter int COUNT_W = 32
) (
	input  logic               clk,
	input  logic               rst_n,
	input  word_t              instr,
	input  word_t              pc,
	input  logic               in_valid,
	input  logic               hold,
	input  logic               flush,
	input  wb_t                wb,
	output exe_out_t           exe_out,
	output logic [COUNT_W-1:0] mem_count
);

	reg_idx_t  rd_addr1;
	reg_idx_t  rd_addr2;
	word_t     rd_data1;
	word_t     rd_data2;
	dec_ctrl_t ctrl;
	exe_in_t   stage;

	instr_decode decode_i (
		.instr    (instr),
		.rd_addr1 (rd_addr1),
		.rd_addr2 (rd_addr2),
		.ctrl     (ctrl)
	);

	reg_file regs_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_addr1 (rd_addr1),
		.rd_addr2 (rd_addr2),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2),
		.wb       (wb)
	);

	id_exe #(
		.COUNT_W (COUNT_W)
	) id_exe_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.hold      (hold),
		.flush     (flush),
		.ctrl      (ctrl),
		.instr     (instr),
		.pc        (pc),
		.rd_data1  (rd_data1),
		.rd_data2  (rd_data2),
		.stage     (stage),
		.mem_count (mem_count)
	);

	alu alu_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.hold    (hold),
		.stage   (stage),
		.exe_out (exe_out)
	);

endmodule

// File: src/alu.sv
`timescale 1ns/10ps

module alu
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     hold,
	input  exe_in_t  stage,
	output exe_out_t exe_out
);

	word_t result;
	logic  live;

	always_comb begin
		case (stage.alu_op)
			ALU_ADD:  result = stage.op1 + stage.op2;
			ALU_SUB:  result = stage.op1 - stage.op2;
			ALU_AND:  result = stage.op1 & stage.op2;
			ALU_OR:   result = stage.op1 | stage.op2;
			ALU_NEQ:  result = (stage.op1 != stage.op2) ? 16'd1 : 16'd0;
			ALU_SLL:  result = stage.op1 << stage.op2;
			ALU_SRL:  result = stage.op1 >> stage.op2;
			ALU_SRA:  result = $signed(stage.op1) >>> stage.op2;
			ALU_SRAV: result = $signed(stage.op2) >>> stage.op1[3:0]; // Amount from op1
			ALU_PASS: result = stage.op1;
			default:  result = stage.op1;
		endcase
	end

	// Every executed form writes a register or touches memory,
	// so a bubble is anything that does neither
	assign live = stage.reg_write || stage.mem_read || stage.mem_write;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exe_out <= '0;
		end else if (!hold) begin
			exe_out.valid <= live;
			exe_out.result <= result;
			exe_out.reg_write <= stage.reg_write;
			exe_out.reg_addr <= stage.reg_addr;
			exe_out.mem_read <= stage.mem_read;
			exe_out.mem_write <= stage.mem_write;
			exe_out.store_value <= stage.store_value;
		end
	end

endmodule

// File: src/id_exe.sv
`timescale 1ns/10ps

module id_exe
	import isa_pkg::*;
	import pipe_pkg::*;
#(
	parameter int COUNT_W = 32
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  logic               hold,
	input  logic               flush,
	input  dec_ctrl_t          ctrl,
	input  word_t              instr,
	input  word_t              pc,
	input  word_t              rd_data1,
	input  word_t              rd_data2,
	output exe_in_t            stage,
	output logic [COUNT_W-1:0] mem_count
);

	word_t   imm;
	word_t   pc_plus1;
	word_t   op1;
	word_t   op2;
	logic    is_sw_sp;
	exe_in_t nxt;
	logic    cnt_inc;

	////////////////////
	// Immediate extension

	always_comb begin
		case (ctrl.imm_kind)
			IMM_S8:    imm = {{8{instr[7]}}, instr[7:0]};
			IMM_S4:    imm = {{12{instr[3]}}, instr[3:0]};
			IMM_S5:    imm = {{11{instr[4]}}, instr[4:0]};
			IMM_Z8:    imm = {8'h00, instr[7:0]};
			IMM_SHAMT: imm = (instr[4:2] == 3'd0) ? SHAMT_ZERO_MEANS : {13'd0, instr[4:2]};
			default:   imm = '0;
		endcase
	end

	assign pc_plus1 = pc + 16'd1;

	////////////////////
	// Operand select

	always_comb begin
		case (ctrl.op1_sel)
			OP1_REG1: op1 = rd_data1;
			OP1_REG2: op1 = rd_data2; // MOVE, shifts, SW_SP base
			OP1_PC1:  op1 = pc_plus1;
			OP1_IMM:  op1 = imm;
			default:  op1 = '0;
		endcase
	end

	always_comb begin
		case (ctrl.op2_sel)
			OP2_REG2: op2 = rd_data2;
			OP2_IMM:  op2 = imm;
			default:  op2 = '0;
		endcase
	end

	// SW_SP keeps its data register on port 1
	assign is_sw_sp = (major_op_e'(instr[15:11]) == OP_SW_SP);

	always_comb begin
		nxt = EXE_IN_BUBBLE;
		if (in_valid) begin
			nxt.alu_op = ctrl.alu_op;
			nxt.op1 = op1;
			nxt.op2 = op2;
			nxt.reg_write = ctrl.reg_write;
			nxt.reg_addr = ctrl.reg_addr;
			nxt.mem_read = ctrl.mem_read;
			nxt.mem_write = ctrl.mem_write;
			nxt.store_value = ctrl.mem_write ? (is_sw_sp ? rd_data1 : rd_data2) : '0;
			nxt.pc = pc;
		end
	end

	assign cnt_inc = !flush && (nxt.mem_read || nxt.mem_write);

	////////////////////
	// Pipeline register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage <= EXE_IN_BUBBLE;
			mem_count <= '0;
		end else if (!hold) begin // Hold wins over flush
			stage <= flush ? EXE_IN_BUBBLE : nxt;
			if (cnt_inc)
				mem_count <= mem_count + COUNT_W'(1); // Wraps
		end
	end

endmodule

// File: src/reg_file.sv
`timescale 1ns/10ps

module reg_file
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  reg_idx_t rd_addr1,
	input  reg_idx_t rd_addr2,
	output word_t    rd_data1,
	output word_t    rd_data2,
	input  wb_t      wb
);

	word_t regs [NUM_REGS];

	logic wr_ok;
	logic rd1_ok;
	logic rd2_ok;

	assign wr_ok = wb.en && (int'(wb.addr) < NUM_REGS);
	assign rd1_ok = int'(rd_addr1) < NUM_REGS;
	assign rd2_ok = int'(rd_addr2) < NUM_REGS;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_ok) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// Reads see the value before a same-cycle write
	assign rd_data1 = rd1_ok ? regs[rd_addr1] : '0;
	assign rd_data2 = rd2_ok ? regs[rd_addr2] : '0;

endmodule

// File: src/instr_decode.sv
`timescale 1ns/10ps

module instr_decode
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  word_t     instr,
	output reg_idx_t  rd_addr1,
	output reg_idx_t  rd_addr2,
	output dec_ctrl_t ctrl
);

	major_op_e major;
	reg_idx_t  rx;
	reg_idx_t  ry;
	reg_idx_t  rz;

	assign major = major_op_e'(instr[15:11]);
	assign rx = {1'b0, instr[10:8]};
	assign ry = {1'b0, instr[7:5]};
	assign rz = {1'b0, instr[4:2]};

	// Builds a control word for an ALU form
	function automatic dec_ctrl_t mk_ctrl(
		input alu_op_e   op,
		input imm_kind_e kind,
		input op1_sel_e  s1,
		input op2_sel_e  s2,
		input logic      wr,
		input reg_idx_t  dst
	);
		dec_ctrl_t c;
		c = CTRL_NOP;
		c.alu_op = op;
		c.imm_kind = kind;
		c.op1_sel = s1;
		c.op2_sel = s2;
		c.reg_write = wr;
		c.reg_addr = dst;
		return c;
	endfunction

	always_comb begin
		rd_addr1 = rx;
		rd_addr2 = ry;
		ctrl = CTRL_NOP;
		case (major)
			OP_ADDIU:  ctrl = mk_ctrl(ALU_ADD, IMM_S8, OP1_REG1, OP2_IMM, 1'b1, rx);
			OP_ADDIU3: ctrl = mk_ctrl(ALU_ADD, IMM_S4, OP1_REG1, OP2_IMM, 1'b1, ry);
			OP_SP_GRP: begin
				if (instr[10:8] == 3'b011) begin // ADDSP
					rd_addr1 = SP_IDX;
					ctrl = mk_ctrl(ALU_ADD, IMM_S8, OP1_REG1, OP2_IMM, 1'b1, SP_IDX);
				end else if (instr[10:8] == 3'b100 && instr[4:0] == 5'b00000) begin
					rd_addr1 = ry; // MTSP, source in 7:5
					ctrl = mk_ctrl(ALU_PASS, IMM_NONE, OP1_REG1, OP2_ZERO, 1'b1, SP_IDX);
				end
			end
			OP_RRR: begin
				if (instr[1:0] == 2'b01)
					ctrl = mk_ctrl(ALU_ADD, IMM_NONE, OP1_REG1, OP2_REG2, 1'b1, rz);
				else if (instr[1:0] == 2'b11)
					ctrl = mk_ctrl(ALU_SUB, IMM_NONE, OP1_REG1, OP2_REG2, 1'b1, rz);
			end
			OP_RR: begin
				if (instr[4:0] == 5'b01100) // AND
					ctrl = mk_ctrl(ALU_AND, IMM_NONE, OP1_REG1, OP2_REG2, 1'b1, rx);
				else if (instr[4:0] == 5'b01010) // CMP, result to T
					ctrl = mk_ctrl(ALU_NEQ, IMM_NONE, OP1_REG1, OP2_REG2, 1'b1, T_IDX);
				else if (instr[7:0] == 8'b01000000) // MFPC
					ctrl = mk_ctrl(ALU_PASS, IMM_NONE, OP1_PC1, OP2_ZERO, 1'b1, rx);
				else if (instr[4:0] == 5'b01101) // OR
					ctrl = mk_ctrl(ALU_OR, IMM_NONE, OP1_REG1, OP2_REG2, 1'b1, rx);
				else if (instr[4:0] == 5'b00111) // SRAV
					ctrl = mk_ctrl(ALU_SRAV, IMM_NONE, OP1_REG1, OP2_REG2, 1'b1, rx);
				// JR, JALR and JRRA fall through as bubbles
			end
			OP_LI:     ctrl = mk_ctrl(ALU_PASS, IMM_Z8, OP1_IMM, OP2_ZERO, 1'b1, rx);
			OP_LW: begin
				ctrl = mk_ctrl(ALU_ADD, IMM_S5, OP1_REG1, OP2_IMM, 1'b1, ry);
				ctrl.mem_read = 1'b1;
			end
			OP_LW_SP: begin
				rd_addr1 = SP_IDX;
				ctrl = mk_ctrl(ALU_ADD, IMM_S8, OP1_REG1, OP2_IMM, 1'b1, rx);
				ctrl.mem_read = 1'b1;
			end
			OP_SW: begin
				ctrl = mk_ctrl(ALU_ADD, IMM_S5, OP1_REG1, OP2_IMM, 1'b0, 4'd0);
				ctrl.mem_write = 1'b1; // Data from port 2
			end
			OP_SW_SP: begin
				rd_addr2 = SP_IDX; // Base on port 2, data rx on port 1
				ctrl = mk_ctrl(ALU_ADD, IMM_S8, OP1_REG2, OP2_IMM, 1'b0, 4'd0);
				ctrl.mem_write = 1'b1;
			end
			OP_IH: begin
				if (instr[7:0] == 8'b00000000) begin // MFIH
					rd_addr1 = IH_IDX;
					ctrl = mk_ctrl(ALU_PASS, IMM_NONE, OP1_REG1, OP2_ZERO, 1'b1, rx);
				end else if (instr[4:0] == 5'b00001) begin // MTIH
					ctrl = mk_ctrl(ALU_PASS, IMM_NONE, OP1_REG1, OP2_ZERO, 1'b1, IH_IDX);
				end
			end
			OP_SHIFT: begin
				if (instr[1:0] == 2'b00)
					ctrl = mk_ctrl(ALU_SLL, IMM_SHAMT, OP1_REG2, OP2_IMM, 1'b1, rx);
				else if (instr[1:0] == 2'b11)
					ctrl = mk_ctrl(ALU_SRA, IMM_SHAMT, OP1_REG2, OP2_IMM, 1'b1, rx);
				else if (instr[1:0] == 2'b10)
					ctrl = mk_ctrl(ALU_SRL, IMM_SHAMT, OP1_REG2, OP2_IMM, 1'b1, rx);
			end
			OP_MOVE: begin
				if (instr[4:0] == 5'b00000)
					ctrl = mk_ctrl(ALU_PASS, IMM_NONE, OP1_REG2, OP2_ZERO, 1'b1, rx);
			end
			default: ctrl = CTRL_NOP; // Branches not executed here
		endcase
	end

endmodule

// File: src/pipe_pkg.sv
package pipe_pkg;

	import isa_pkg::*;

	typedef enum logic [2:0] {
		OP1_REG1,
		OP1_REG2,
		OP1_PC1,
		OP1_IMM,
		OP1_ZERO
	} op1_sel_e;

	typedef enum logic [1:0] {
		OP2_REG2,
		OP2_IMM,
		OP2_ZERO
	} op2_sel_e;

	////////////////////
	// Stage payloads

	typedef struct packed {
		alu_op_e   alu_op;
		imm_kind_e imm_kind;
		op1_sel_e  op1_sel;
		op2_sel_e  op2_sel;
		logic      reg_write;
		reg_idx_t  reg_addr;
		logic      mem_read;
		logic      mem_write;
	} dec_ctrl_t;

	typedef struct packed {
		alu_op_e  alu_op;
		word_t    op1;
		word_t    op2;
		logic     reg_write;
		reg_idx_t reg_addr;
		logic     mem_read;
		logic     mem_write;
		word_t    store_value;
		word_t    pc;
	} exe_in_t;

	typedef struct packed {
		logic     en;
		reg_idx_t addr;
		word_t    data;
	} wb_t;

	typedef struct packed {
		logic     valid;
		word_t    result;
		logic     reg_write;
		reg_idx_t reg_addr;
		logic     mem_read;
		logic     mem_write;
		word_t    store_value;
	} exe_out_t;

	// Control word that writes nothing
	localparam dec_ctrl_t CTRL_NOP = '{
		alu_op: ALU_PASS, imm_kind: IMM_NONE, op1_sel: OP1_ZERO, op2_sel: OP2_ZERO,
		reg_write: 1'b0, reg_addr: 4'd0, mem_read: 1'b0, mem_write: 1'b0
	};

	localparam exe_in_t EXE_IN_BUBBLE = '{
		alu_op: ALU_PASS, op1: 16'd0, op2: 16'd0, reg_write: 1'b0, reg_addr: 4'd0,
		mem_read: 1'b0, mem_write: 1'b0, store_value: 16'd0, pc: 16'd0
	};

endpackage

// File: src/isa_pkg.sv
package isa_pkg;

	////////////////////
	// Data and register indices

	typedef logic [15:0] word_t;
	typedef logic [3:0] reg_idx_t;

	localparam int NUM_REGS = 12; // R0-R7, SP, IH, RA, T

	localparam reg_idx_t SP_IDX = 4'd8;
	localparam reg_idx_t IH_IDX = 4'd9;
	localparam reg_idx_t T_IDX = 4'd11;

	// A 3-bit shift field of zero encodes a shift by eight
	localparam word_t SHAMT_ZERO_MEANS = 16'd8;

	////////////////////
	// Major opcode, instr[15:11]

	typedef enum logic [4:0] {
		OP_NOP    = 5'b00001,
		OP_B      = 5'b00010,
		OP_BEQZ   = 5'b00100,
		OP_BNEZ   = 5'b00101,
		OP_SHIFT  = 5'b00110, // SLL, SRL, SRA
		OP_ADDIU3 = 5'b01000,
		OP_ADDIU  = 5'b01001,
		OP_SP_GRP = 5'b01100, // ADDSP, MTSP, BTEQZ, BTNEZ
		OP_LI     = 5'b01101,
		OP_MOVE   = 5'b01111,
		OP_LW_SP  = 5'b10010,
		OP_LW     = 5'b10011,
		OP_SW_SP  = 5'b11010,
		OP_SW     = 5'b11011,
		OP_RRR    = 5'b11100, // ADDU, SUBU
		OP_RR     = 5'b11101, // AND, OR, CMP, SRAV, MFPC, jumps
		OP_IH     = 5'b11110  // MFIH, MTIH
	} major_op_e;

	////////////////////
	// Execute operation

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NEQ,
		ALU_SLL,
		ALU_SRA,
		ALU_SRL,
		ALU_SRAV,
		ALU_PASS
	} alu_op_e;

	// Which immediate field is extended, and how
	typedef enum logic [2:0] {
		IMM_S8,    // instr[7:0] signed
		IMM_S4,    // instr[3:0] signed
		IMM_S5,    // instr[4:0] signed
		IMM_Z8,    // instr[7:0] unsigned
		IMM_SHAMT, // instr[4:2], 0 is 8
		IMM_NONE
	} imm_kind_e;

endpackage
